// File: simd_cfg_pkg.sv
// SIMD driver configuration
// Dimension count, field widths and issue limits shared by every block

package simd_cfg_pkg;

	// ================================================
	// Offset space
	// ================================================
	// Number of offset dimensions, dimension 0 is innermost
	localparam int VDIM = 2;
	// Bits per offset
	localparam int WBW = 8;

	// ================================================
	// Instruction store
	// ================================================
	// Number of instruction slots
	localparam int N_INST = 16;
	// Wide enough for N_INST as an exclusive end index
	localparam int INST_BW = $clog2(N_INST + 1);

	// ================================================
	// Issue control
	// ================================================
	// Warp ids wrap at this count
	localparam int MAX_WARP = 8;
	localparam int WID_BW = $clog2(MAX_WARP);
	// Bound on issued but uncommitted instructions
	localparam int N_PENDING = 4;
	// Holds 0 .. N_PENDING inclusive
	localparam int PEND_BW = $clog2(N_PENDING + 1);

endpackage

// File: simd_types_pkg.sv
// SIMD driver data types
// Offset and pc vectors, command, tuple and instruction records, FSM states

package simd_types_pkg;

	// ================================================
	// Scalar fields
	// ================================================
	// One offset along one dimension
	typedef logic [simd_cfg_pkg::WBW-1:0] ofs_t;
	// Instruction index, also used as exclusive range end
	typedef logic [simd_cfg_pkg::INST_BW-1:0] pc_t;
	// Warp id carried with each instruction
	typedef logic [simd_cfg_pkg::WID_BW-1:0] warpid_t;
	// All dimensions of one offset, entry 0 is innermost
	typedef ofs_t [simd_cfg_pkg::VDIM-1:0] ofs_vec_t;

	// ================================================
	// Records on the rdy/ack links
	// ================================================
	// Command from the abofs port
	typedef struct packed {
		ofs_vec_t bofs;
		ofs_vec_t aofs_beg;
		ofs_vec_t aofs_end;
		// Entry k applies when dimension k is the lowest one not at its end
		pc_t [simd_cfg_pkg::VDIM:0] id_begs;
		pc_t [simd_cfg_pkg::VDIM:0] id_ends;
	} cmd_t;

	// One walked A-offset tuple with its instruction range
	typedef struct packed {
		ofs_vec_t aofs;
		pc_t      id_beg;
		pc_t      id_end;
		logic     islast;
	} tuple_t;

	// One issued instruction
	typedef struct packed {
		pc_t      pc;
		warpid_t  warpid;
		ofs_vec_t bofs;
		ofs_vec_t aofs;
	} inst_t;

	// ================================================
	// FSM states
	// ================================================
	typedef enum logic {LOOP_IDLE, LOOP_RUN} loop_state_t;
	typedef enum logic {ISS_IDLE, ISS_RUN} issue_state_t;

endpackage

// File: rdyack_broadcast.sv
// Two-way rdy/ack fork
// Offers one source to two consumers and acks the source once both have taken it

`timescale 1ns/10ps

module rdyack_broadcast (
	input  logic       i_clk,
	input  logic       i_rst,
	// Source side
	input  logic       i_src_rdy,
	output logic       o_src_ack,
	// Consumer side, one bit per consumer
	output logic [1:0] o_dst_rdys,
	input  logic [1:0] i_dst_acks
);

	// Consumers that have already acknowledged the current source
	logic [1:0] done_r;
	// Done after this cycle
	logic [1:0] done_now;

	// ================================================
	// Handshake
	// ================================================
	// Each consumer sees rdy until it has taken the item
	assign o_dst_rdys = {2{i_src_rdy}} & ~done_r;
	assign done_now = done_r | i_dst_acks;
	// Source completes in the cycle the second consumer acks
	assign o_src_ack = i_src_rdy && (&done_now);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			done_r <= '0;
		end else if (o_src_ack) begin
			// Ready for the next source item
			done_r <= '0;
		end else begin
			done_r <= done_now;
		end
	end

	// ================================================
	// Checks
	// ================================================
	// A consumer acks only while its rdy is up
	a_ack_needs_rdy: assert property (
		@(posedge i_clk) disable iff (i_rst)
		(i_dst_acks & ~o_dst_rdys) == 2'b00
	);

	// Source rdy must hold until it is acknowledged
	a_src_held: assert property (
		@(posedge i_clk) disable iff (i_rst)
		(i_src_rdy && !o_src_ack) |=> i_src_rdy
	);

endmodule

// File: ofs_looper.sv
// A-offset box walker
// Emits one tuple per cycle over the box with its selected instruction range

`timescale 1ns/10ps

module ofs_looper (
	input  logic                   i_clk,
	input  logic                   i_rst,
	// Command, held by the source until acked
	input  logic                   i_src_rdy,
	output logic                   o_src_ack,
	input  simd_types_pkg::cmd_t   i_cmd,
	// Tuple stream
	output logic                   o_dst_rdy,
	input  logic                   i_dst_ack,
	output simd_types_pkg::tuple_t o_tuple
);

	simd_types_pkg::loop_state_t   state_r;
	// Current tuple
	simd_types_pkg::ofs_vec_t      cnt_r;
	// Tuple after the current one
	simd_types_pkg::ofs_vec_t      cnt_nxt;
	// Per dimension, offset sits at aofs_end minus one
	logic [simd_cfg_pkg::VDIM-1:0] at_end;
	logic                          islast;
	simd_types_pkg::pc_t           id_beg_sel;
	simd_types_pkg::pc_t           id_end_sel;

	// ================================================
	// Walk arithmetic
	// ================================================
	always_comb begin
		for (int d = 0; d < simd_cfg_pkg::VDIM; d++) begin
			at_end[d] = cnt_r[d] == (i_cmd.aofs_end[d] - simd_types_pkg::ofs_t'(1));
		end
	end

	// Final tuple when every dimension is at its end
	assign islast = &at_end;

	// Odometer step, dimension 0 first
	always_comb begin : step_cnt
		logic carry;
		carry = 1'b1;
		for (int d = 0; d < simd_cfg_pkg::VDIM; d++) begin
			if (!carry) begin
				cnt_nxt[d] = cnt_r[d];
			end else if (at_end[d]) begin
				// Wrap and carry upward
				cnt_nxt[d] = i_cmd.aofs_beg[d];
			end else begin
				cnt_nxt[d] = cnt_r[d] + simd_types_pkg::ofs_t'(1);
			end
			carry = carry & at_end[d];
		end
	end

	// Range select
	// Lowest dimension not at its end picks the entry, all at end picks VDIM
	always_comb begin
		id_beg_sel = i_cmd.id_begs[simd_cfg_pkg::VDIM];
		id_end_sel = i_cmd.id_ends[simd_cfg_pkg::VDIM];
		for (int d = simd_cfg_pkg::VDIM - 1; d >= 0; d--) begin
			if (!at_end[d]) begin
				id_beg_sel = i_cmd.id_begs[d];
				id_end_sel = i_cmd.id_ends[d];
			end
		end
	end

	// ================================================
	// Outputs
	// ================================================
	assign o_dst_rdy = state_r == simd_types_pkg::LOOP_RUN;
	// Command is released with its last tuple
	assign o_src_ack = o_dst_rdy && i_dst_ack && islast;

	assign o_tuple.aofs = cnt_r;
	assign o_tuple.id_beg = id_beg_sel;
	assign o_tuple.id_end = id_end_sel;
	assign o_tuple.islast = islast;

	// ================================================
	// State
	// ================================================
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state_r <= simd_types_pkg::LOOP_IDLE;
		end else begin
			case (state_r)
				// Start on a pending command, first tuple next cycle
				simd_types_pkg::LOOP_IDLE: if (i_src_rdy) state_r <= simd_types_pkg::LOOP_RUN;
				simd_types_pkg::LOOP_RUN: if (o_src_ack) state_r <= simd_types_pkg::LOOP_IDLE;
				default: state_r <= simd_types_pkg::LOOP_IDLE;
			endcase
		end
	end

	// Idle keeps the counters parked at the box origin
	always_ff @(posedge i_clk) begin
		if (state_r == simd_types_pkg::LOOP_IDLE) begin
			cnt_r <= i_cmd.aofs_beg;
		end else if (i_dst_ack) begin
			cnt_r <= cnt_nxt;
		end
	end

	// ================================================
	// Checks
	// ================================================
	for (genvar gd = 0; gd < simd_cfg_pkg::VDIM; gd++) begin : g_bound
		a_ofs_in_box: assert property (
			@(posedge i_clk) disable iff (i_rst)
			state_r == simd_types_pkg::LOOP_RUN |-> cnt_r[gd] < i_cmd.aofs_end[gd]
		);
	end

endmodule

// File: inst_issue_stage.sv
// Instruction issue stage
// Drops empty ranges and steps the pc over each non-empty one, tagging warp ids

`timescale 1ns/10ps

module inst_issue_stage (
	input  logic                     i_clk,
	input  logic                     i_rst,
	// Tuple stream from the looper
	input  logic                     i_src_rdy,
	output logic                     o_src_ack,
	input  simd_types_pkg::tuple_t   i_tuple,
	input  simd_types_pkg::ofs_vec_t i_bofs,
	// Instruction stream
	output logic                     o_dst_rdy,
	input  logic                     i_dst_ack,
	output simd_types_pkg::inst_t    o_inst,
	// Pulse when the final tuple of a command is done
	output logic                     o_last_done
);

	simd_types_pkg::issue_state_t state_r;
	// Registered range and tuple payload
	simd_types_pkg::pc_t          pc_r;
	simd_types_pkg::pc_t          end_r;
	simd_types_pkg::ofs_vec_t     aofs_r;
	logic                         islast_r;
	simd_types_pkg::warpid_t      warp_r;
	simd_types_pkg::pc_t          pc_nxt;
	logic                         take;
	logic                         empty;
	logic                         fire;
	logic                         pc_last;

	// ================================================
	// Handshake
	// ================================================
	// Any offered tuple is taken while idle
	assign take = state_r == simd_types_pkg::ISS_IDLE && i_src_rdy;
	assign o_src_ack = take;
	assign empty = i_tuple.id_beg == i_tuple.id_end;

	assign o_dst_rdy = state_r == simd_types_pkg::ISS_RUN;
	assign fire = o_dst_rdy && i_dst_ack;
	assign pc_nxt = pc_r + simd_types_pkg::pc_t'(1);
	assign pc_last = pc_nxt == end_r;

	// Final tuple either dropped on arrival or its last pc issued
	assign o_last_done = (take && empty && i_tuple.islast) || (fire && pc_last && islast_r);

	assign o_inst.pc = pc_r;
	assign o_inst.warpid = warp_r;
	assign o_inst.bofs = i_bofs;
	assign o_inst.aofs = aofs_r;

	// ================================================
	// State and warp counter
	// ================================================
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state_r <= simd_types_pkg::ISS_IDLE;
		end else begin
			case (state_r)
				simd_types_pkg::ISS_IDLE: if (take && !empty) state_r <= simd_types_pkg::ISS_RUN;
				simd_types_pkg::ISS_RUN: if (fire && pc_last) state_r <= simd_types_pkg::ISS_IDLE;
				default: state_r <= simd_types_pkg::ISS_IDLE;
			endcase
		end
	end

	// One warp per non-empty tuple, restarting for each command
	always_ff @(posedge i_clk) begin
		if (i_rst || o_last_done) begin
			warp_r <= '0;
		end else if (fire && pc_last) begin
			if (warp_r == simd_types_pkg::warpid_t'(simd_cfg_pkg::MAX_WARP - 1)) begin
				warp_r <= '0;
			end else begin
				warp_r <= warp_r + simd_types_pkg::warpid_t'(1);
			end
		end
	end

	// Range payload
	always_ff @(posedge i_clk) begin
		if (take) begin
			pc_r <= i_tuple.id_beg;
			end_r <= i_tuple.id_end;
			aofs_r <= i_tuple.aofs;
			islast_r <= i_tuple.islast;
		end else if (fire) begin
			pc_r <= pc_nxt;
		end
	end

	// ================================================
	// Checks
	// ================================================
	a_pc_in_range: assert property (
		@(posedge i_clk) disable iff (i_rst)
		state_r == simd_types_pkg::ISS_RUN |-> pc_r < end_r
	);

endmodule

// File: pending_limiter.sv
// Outstanding instruction limiter
// Holds issue back at N_PENDING uncommitted instructions and flags when none remain

`timescale 1ns/10ps

module pending_limiter (
	input  logic i_clk,
	input  logic i_rst,
	// Instruction stream from the issue stage
	input  logic i_src_rdy,
	output logic o_src_ack,
	// Instruction stream to the outside
	output logic o_dst_rdy,
	input  logic i_dst_ack,
	// One strobe per retired instruction
	input  logic i_commit,
	// No instruction outstanding
	output logic o_idle
);

	// Issued but not yet committed
	logic [simd_cfg_pkg::PEND_BW-1:0] cnt_r;
	logic                             xfer;
	logic                             room;

	// ================================================
	// Gating
	// ================================================
	assign room = cnt_r < simd_cfg_pkg::PEND_BW'(simd_cfg_pkg::N_PENDING);
	// Offer only while below the bound
	assign o_dst_rdy = i_src_rdy && room;
	assign xfer = o_dst_rdy && i_dst_ack;
	assign o_src_ack = xfer;
	assign o_idle = cnt_r == '0;

	// ================================================
	// Counter
	// ================================================
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			cnt_r <= '0;
		end else begin
			case ({xfer, i_commit})
				2'b10: cnt_r <= cnt_r + 1'b1;
				2'b01: cnt_r <= cnt_r - 1'b1;
				// Issue and commit together leave the count unchanged
				default: cnt_r <= cnt_r;
			endcase
		end
	end

	// ================================================
	// Checks
	// ================================================
	a_cnt_bounded: assert property (
		@(posedge i_clk) disable iff (i_rst)
		cnt_r <= simd_cfg_pkg::PEND_BW'(simd_cfg_pkg::N_PENDING)
	);

	// Commits only retire instructions issued in earlier cycles
	a_no_commit_at_zero: assert property (
		@(posedge i_clk) disable iff (i_rst)
		i_commit |-> cnt_r != '0
	);

	// A stalled offer stays up until it goes out
	a_rdy_held: assert property (
		@(posedge i_clk) disable iff (i_rst)
		(o_dst_rdy && !i_dst_ack) |=> o_dst_rdy
	);

endmodule

// File: simd_driver.sv
// SIMD tile engine instruction driver
// Walks the A-offset box of a command and issues its instructions under a pending bound

`timescale 1ns/10ps

module simd_driver (
	input  logic                  i_clk,
	input  logic                  i_rst,
	// Command port
	input  logic                  i_abofs_rdy,
	output logic                  o_abofs_ack,
	input  simd_types_pkg::cmd_t  i_cmd,
	// Instruction port
	output logic                  o_inst_rdy,
	input  logic                  i_inst_ack,
	output simd_types_pkg::inst_t o_inst,
	// Retire strobe
	input  logic                  i_inst_commit
);

	// Broadcast branches, bit 0 walks and bit 1 waits for completion
	logic [1:0]             brd_rdys;
	logic [1:0]             brd_acks;
	// Looper to issue stage
	logic                   tup_rdy;
	logic                   tup_ack;
	simd_types_pkg::tuple_t tup;
	// Issue stage to limiter
	logic                   iss_rdy;
	logic                   iss_ack;
	logic                   last_done;
	logic                   lim_idle;
	// Every tuple of the current command has left the issue stage
	logic                   walk_done_r;

	// ================================================
	// Command fork
	// ================================================
	rdyack_broadcast u_brd (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_src_rdy(i_abofs_rdy), .o_src_ack(o_abofs_ack),
		.o_dst_rdys(brd_rdys), .i_dst_acks(brd_acks)
	);

	// Completion ack waits for the walk and for every commit
	assign brd_acks[1] = brd_rdys[1] && walk_done_r && lim_idle;

	always_ff @(posedge i_clk) begin
		if (i_rst || o_abofs_ack) begin
			walk_done_r <= 1'b0;
		end else if (last_done) begin
			walk_done_r <= 1'b1;
		end
	end

	// ================================================
	// Walk and issue pipeline
	// ================================================
	ofs_looper u_looper (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_src_rdy(brd_rdys[0]), .o_src_ack(brd_acks[0]), .i_cmd(i_cmd),
		.o_dst_rdy(tup_rdy), .i_dst_ack(tup_ack), .o_tuple(tup)
	);

	inst_issue_stage u_issue (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_src_rdy(tup_rdy), .o_src_ack(tup_ack), .i_tuple(tup), .i_bofs(i_cmd.bofs),
		.o_dst_rdy(iss_rdy), .i_dst_ack(iss_ack), .o_inst(o_inst),
		.o_last_done(last_done)
	);

	// Pause issue while too many instructions are in flight
	pending_limiter u_limit (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_src_rdy(iss_rdy), .o_src_ack(iss_ack),
		.o_dst_rdy(o_inst_rdy), .i_dst_ack(i_inst_ack),
		.i_commit(i_inst_commit), .o_idle(lim_idle)
	);

	// Instructions only flow while a command is being held
	a_inst_within_cmd: assert property (
		@(posedge i_clk) disable iff (i_rst)
		o_inst_rdy |-> i_abofs_rdy && !o_abofs_ack
	);

endmodule

// File: tb_simd_driver.sv
// Testbench for the SIMD instruction driver
// Drives LFSR commands with back-pressure and checks a reference sequence by assertions

`timescale 1ns/10ps

module tb_simd_driver;

	localparam int N_CMDS = 40;
	localparam int CYC_PER_CMD = 200;
	localparam int MAX_CYCLES = N_CMDS * CYC_PER_CMD;
	localparam int VDIM = simd_cfg_pkg::VDIM;

	logic                  i_clk;
	logic                  i_rst;
	logic                  i_abofs_rdy;
	logic                  o_abofs_ack;
	simd_types_pkg::cmd_t  i_cmd;
	logic                  o_inst_rdy;
	logic                  i_inst_ack;
	simd_types_pkg::inst_t o_inst;
	logic                  i_inst_commit;

	logic [15:0]           lfsr;
	// Reference sequence of the command in flight
	simd_types_pkg::inst_t exp_mem [256];
	simd_types_pkg::inst_t exp_head;
	int                    exp_cnt;
	int                    exp_idx;
	// Issued minus committed as seen from the ports
	int                    pend;
	int                    cmds_sent;
	int                    acks_seen;
	int                    cycle = 0;
	logic                  xfer;
	logic                  xfer_q;
	// Cycle at which each outstanding instruction commits
	int                    commit_q [$];
	int                    seq_err = 0;
	int                    warp_err = 0;
	int                    pend_err = 0;
	int                    stall_err = 0;
	int                    ack_err = 0;

	simd_driver u_dut (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_abofs_rdy(i_abofs_rdy), .o_abofs_ack(o_abofs_ack), .i_cmd(i_cmd),
		.o_inst_rdy(o_inst_rdy), .i_inst_ack(i_inst_ack), .o_inst(o_inst),
		.i_inst_commit(i_inst_commit)
	);

	always #10 i_clk = ~i_clk;

	// ================================================
	// Stimulus helpers
	// ================================================
	// Fibonacci LFSR x^16+x^14+x^13+x^11+1 stepped once per bit
	function automatic int draw(int nbits);
		int   v;
		logic fb;
		v = 0;
		for (int i = 0; i < nbits; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			v = (v << 1) | int'(fb);
		end
		return v;
	endfunction

	task automatic make_cmd(output simd_types_pkg::cmd_t c);
		int lo;
		int len;
		for (int d = 0; d < VDIM; d++) begin
			c.bofs[d] = simd_types_pkg::ofs_t'(draw(8));
			c.aofs_beg[d] = simd_types_pkg::ofs_t'(draw(7));
			// Box is 1 to 3 wide
			c.aofs_end[d] = c.aofs_beg[d] + simd_types_pkg::ofs_t'(1 + draw(2) % 3);
		end
		for (int k = 0; k <= VDIM; k++) begin
			lo = draw(4);
			len = draw(3);
			// About one entry in four forced empty
			if (draw(2) == 0) begin
				len = 0;
			end
			if (lo + len > simd_cfg_pkg::N_INST) begin
				len = simd_cfg_pkg::N_INST - lo;
			end
			c.id_begs[k] = simd_types_pkg::pc_t'(lo);
			c.id_ends[k] = simd_types_pkg::pc_t'(lo + len);
		end
	endtask

	// Expected instruction stream from the walk order and the range rule
	task automatic build_model(input simd_types_pkg::cmd_t c);
		int                       total;
		int                       rem;
		int                       size;
		int                       k;
		int                       w;
		simd_types_pkg::ofs_vec_t a;
		simd_types_pkg::inst_t    ins;
		total = 1;
		for (int d = 0; d < VDIM; d++) begin
			total = total * (int'(c.aofs_end[d]) - int'(c.aofs_beg[d]));
		end
		exp_cnt = 0;
		w = 0;
		for (int t = 0; t < total; t++) begin
			// Dimension 0 runs fastest
			rem = t;
			for (int d = 0; d < VDIM; d++) begin
				size = int'(c.aofs_end[d]) - int'(c.aofs_beg[d]);
				a[d] = c.aofs_beg[d] + simd_types_pkg::ofs_t'(rem % size);
				rem = rem / size;
			end
			k = VDIM;
			for (int d = VDIM - 1; d >= 0; d--) begin
				if (int'(a[d]) != int'(c.aofs_end[d]) - 1) begin
					k = d;
				end
			end
			// Empty range yields nothing and keeps the warp
			if (c.id_begs[k] != c.id_ends[k]) begin
				for (int p = int'(c.id_begs[k]); p < int'(c.id_ends[k]); p++) begin
					ins.pc = simd_types_pkg::pc_t'(p);
					ins.warpid = simd_types_pkg::warpid_t'(w);
					ins.bofs = c.bofs;
					ins.aofs = a;
					exp_mem[exp_cnt] = ins;
					exp_cnt++;
				end
				w = (w + 1) % simd_cfg_pkg::MAX_WARP;
			end
		end
	endtask

	// One cycle of the outside world driven on the falling edge
	task automatic step();
		@(negedge i_clk);
		if (xfer_q) begin
			commit_q.push_back(cycle + draw(2));
		end
		i_inst_commit = 1'b0;
		if (commit_q.size() > 0 && commit_q[0] <= cycle) begin
			void'(commit_q.pop_front());
			i_inst_commit = 1'b1;
		end
		// Ack three times in four while offered
		i_inst_ack = o_inst_rdy && (draw(2) != 0);
	endtask

	// ================================================
	// Monitor and timeout
	// ================================================
	assign xfer = o_inst_rdy && i_inst_ack;
	assign exp_head = exp_mem[exp_idx[7:0]];

	always @(posedge i_clk) begin
		if (i_rst) begin
			exp_idx <= 0;
			pend <= 0;
			acks_seen <= 0;
			xfer_q <= 1'b0;
		end else begin
			xfer_q <= xfer;
			pend <= pend + int'(xfer) - int'(i_inst_commit);
			if (o_abofs_ack) begin
				exp_idx <= 0;
				acks_seen <= acks_seen + 1;
			end else if (xfer) begin
				exp_idx <= exp_idx + 1;
			end
		end
	end

	always @(posedge i_clk) begin
		cycle <= cycle + 1;
		if (cycle >= MAX_CYCLES) begin
			$display("Timeout: run went past %0d cycles", MAX_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	// ================================================
	// Checks
	// ================================================
	a_extra: assert property (@(posedge i_clk) disable iff (i_rst) xfer |-> exp_idx < exp_cnt)
		else begin
			seq_err++;
			$display("Instruction issued beyond the expected %0d", $sampled(exp_cnt));
		end
	a_pc: assert property (@(posedge i_clk) disable iff (i_rst) xfer |-> o_inst.pc == exp_head.pc)
		else begin
			seq_err++;
			$display("Fail pc: expected %0d actual %0d", $sampled(exp_head.pc),
				$sampled(o_inst.pc));
		end
	a_aofs: assert property (@(posedge i_clk) disable iff (i_rst)
		xfer |-> o_inst.aofs == exp_head.aofs)
		else begin
			seq_err++;
			$display("Fail aofs: expected %h actual %h", $sampled(exp_head.aofs),
				$sampled(o_inst.aofs));
		end
	a_bofs: assert property (@(posedge i_clk) disable iff (i_rst)
		xfer |-> o_inst.bofs == exp_head.bofs)
		else begin
			seq_err++;
			$display("Fail bofs: expected %h actual %h", $sampled(exp_head.bofs),
				$sampled(o_inst.bofs));
		end
	a_warp: assert property (@(posedge i_clk) disable iff (i_rst)
		xfer |-> o_inst.warpid == exp_head.warpid)
		else begin
			warp_err++;
			$display("Fail warpid: expected %0d actual %0d", $sampled(exp_head.warpid),
				$sampled(o_inst.warpid));
		end
	a_pend: assert property (@(posedge i_clk) disable iff (i_rst)
		pend <= simd_cfg_pkg::N_PENDING)
		else begin
			pend_err++;
			$display("Fail pending: expected at most %0d actual %0d",
				simd_cfg_pkg::N_PENDING, $sampled(pend));
		end
	// Stalled offer keeps its payload
	a_stall: assert property (@(posedge i_clk) disable iff (i_rst)
		(o_inst_rdy && !i_inst_ack) |=> (o_inst_rdy && $stable(o_inst)))
		else begin
			stall_err++;
			$display("Instruction offer dropped or changed while waiting for ack");
		end
	a_ack_done: assert property (@(posedge i_clk) disable iff (i_rst)
		o_abofs_ack |-> (exp_idx == exp_cnt && pend == 0))
		else begin
			ack_err++;
			$display("Fail cmd done: expected %0d issued, 0 pending, actual %0d, %0d",
				$sampled(exp_cnt), $sampled(exp_idx), $sampled(pend));
		end
	a_ack_once: assert property (@(posedge i_clk) disable iff (i_rst)
		o_abofs_ack |-> acks_seen == cmds_sent - 1)
		else begin
			ack_err++;
			$display("Fail cmd ack count: expected %0d actual %0d", $sampled(cmds_sent) - 1,
				$sampled(acks_seen));
		end
	a_reset_low: assert property (@(posedge i_clk) $past(i_rst) |-> !o_abofs_ack && !o_inst_rdy)
		else begin
			ack_err++;
			$display("Handshake output high right after reset");
		end

	// ================================================
	// Main sequence
	// ================================================
	initial begin
		simd_types_pkg::cmd_t c;
		int                   gap;
		i_clk = 1'b0;
		i_rst = 1'b1;
		i_abofs_rdy = 1'b0;
		i_cmd = '0;
		i_inst_ack = 1'b0;
		i_inst_commit = 1'b0;
		lfsr = 16'd55695;
		exp_cnt = 0;
		cmds_sent = 0;
		repeat (4) @(negedge i_clk);
		i_rst = 1'b0;
		for (int n = 0; n < N_CMDS; n++) begin
			make_cmd(c);
			build_model(c);
			i_cmd = c;
			i_abofs_rdy = 1'b1;
			cmds_sent++;
			do begin
				step();
			end while (!o_abofs_ack);
			// Command completes at the coming edge
			step();
			i_abofs_rdy = 1'b0;
			gap = draw(2);
			repeat (gap) step();
		end
		repeat (4) step();
		a_all_acked: assert (acks_seen == N_CMDS)
			else begin
				ack_err++;
				$display("Fail commands acked: expected %0d actual %0d", N_CMDS, acks_seen);
			end
		$display("Errors: sequence %0d, warp %0d, pending %0d, stall %0d, ack %0d",
			seq_err, warp_err, pend_err, stall_err, ack_err);
		if (seq_err + warp_err + pend_err + stall_err + ack_err == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: tb.f
simd_cfg_pkg.sv
simd_types_pkg.sv
rdyack_broadcast.sv
ofs_looper.sv
inst_issue_stage.sv
pending_limiter.sv
simd_driver.sv
tb_simd_driver.sv

// File: run.sh
#!/bin/sh
# Build and run the SIMD driver testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_simd_driver -o sim_tb
./obj_dir/sim_tb | tee sim.log
if grep -qx "TEST PASSED" sim.log; then
	exit 0
fi
exit 1
